//--- term_pkg.sv
// terminal package: byte type, control codes and the decoder command set
package term_pkg;

   // received byte or screen character
   typedef logic [7:0] byte_t;

   // control characters handled in the normal state
   localparam byte_t code_bs    = 8'h08;
   localparam byte_t code_lf    = 8'h0a;
   localparam byte_t code_cr    = 8'h0d;
   localparam byte_t code_esc   = 8'h1b;

   // fill character, also the bias of ESC Y coordinates
   localparam byte_t code_space = 8'h20;

   // printable range, both ends included
   localparam byte_t print_first = 8'h20;
   localparam byte_t print_last  = 8'h7e;

   // commands from the decoder to the cursor unit, valid in the accept cycle
   typedef enum logic [3:0] {
      cmd_none,
      cmd_print,
      // BS and ESC D
      cmd_left,
      cmd_right,
      cmd_up,
      cmd_down,
      cmd_cr,
      cmd_lf,
      cmd_home,
      cmd_goto,
      cmd_erase_eol
   } cmd_t;

endpackage

//--- vt52_decoder.sv
// vt52 byte parser turning accepted host bytes into cursor and erase commands
`timescale 1ns/1ns

module vt52_decoder #(
   parameter ROWS     = 24,
   parameter COLS     = 80,
   parameter ROW_BITS = 5,
   parameter COL_BITS = 7
) (
   input  logic                clk,
   input  logic                clr,
   input  term_pkg::byte_t     data,
   input  logic                valid,
   input  logic                fill_busy,
   input  logic                goto_busy,
   input  logic [ROW_BITS-1:0] cursor_y,
   output logic                ready,
   output term_pkg::cmd_t      cmd,
   output term_pkg::byte_t     cmd_char,
   output logic [ROW_BITS-1:0] goto_row,
   output logic [COL_BITS-1:0] goto_col
);

   typedef logic [COL_BITS-1:0] col_t;

   // st_row and st_col collect the two ESC Y coordinate bytes
   typedef enum logic [1:0] {
      st_normal,
      st_esc,
      st_row,
      st_col
   } state_t;

   state_t state;

   logic            accept;
   logic            printable;
   term_pkg::byte_t offset;
   logic            row_ok;
   logic            col_ok;

   // no byte is taken while the screen fill or the ESC Y pipeline runs
   assign ready  = !(fill_busy || goto_busy);
   assign accept = valid && ready;

   assign printable = (data >= term_pkg::print_first) && (data <= term_pkg::print_last);

   // coordinate bytes are biased by the space code
   assign offset = data - term_pkg::code_space;
   assign row_ok = (data >= term_pkg::code_space) && (offset < term_pkg::byte_t'(ROWS));
   assign col_ok = (data >= term_pkg::code_space) && (offset < term_pkg::byte_t'(COLS));

   assign cmd_char = data;

   always_comb begin
      cmd = term_pkg::cmd_none;
      if (accept) begin
         case (state)
            st_normal: begin
               if (printable) begin
                  cmd = term_pkg::cmd_print;
               end else begin
                  case (data)
                     term_pkg::code_bs: cmd = term_pkg::cmd_left;
                     term_pkg::code_cr: cmd = term_pkg::cmd_cr;
                     term_pkg::code_lf: cmd = term_pkg::cmd_lf;
                     default:           cmd = term_pkg::cmd_none;
                  endcase
               end
            end
            st_esc: begin
               case (data)
                  "A":     cmd = term_pkg::cmd_up;
                  "B":     cmd = term_pkg::cmd_down;
                  "C":     cmd = term_pkg::cmd_right;
                  "D":     cmd = term_pkg::cmd_left;
                  "H":     cmd = term_pkg::cmd_home;
                  "K":     cmd = term_pkg::cmd_erase_eol;
                  default: cmd = term_pkg::cmd_none;
               endcase
            end
            // column byte completes ESC Y
            st_col:  cmd = term_pkg::cmd_goto;
            default: cmd = term_pkg::cmd_none;
         endcase
      end
   end

   always_ff @(posedge clk or posedge clr) begin
      if (clr) begin
         state <= st_normal;
      end else if (accept) begin
         case (state)
            st_normal: begin
               if (data == term_pkg::code_esc) begin
                  state <= st_esc;
               end
            end
            st_esc: begin
               // a second ESC keeps the sequence open
               if (data == "Y") begin
                  state <= st_row;
               end else if (data != term_pkg::code_esc) begin
                  state <= st_normal;
               end
            end
            st_row:  state <= st_col;
            st_col:  state <= st_normal;
            default: state <= st_normal;
         endcase
      end
   end

   // out of range row keeps the current row and out of range column goes to the last one
   always_ff @(posedge clk) begin
      if (accept && state == st_row) begin
         goto_row <= row_ok ? offset[ROW_BITS-1:0] : cursor_y;
      end
      if (accept && state == st_col) begin
         goto_col <= col_ok ? offset[COL_BITS-1:0] : col_t'(COLS-1);
      end
   end

endmodule

//--- cursor_unit.sv
// cursor unit: cursor position, row and character addresses, scroll origin, ESC Y pipeline
`timescale 1ns/1ns

module cursor_unit #(
   parameter ROWS      = 24,
   parameter COLS      = 80,
   parameter ROW_BITS  = 5,
   parameter COL_BITS  = 7,
   parameter ADDR_BITS = 11
) (
   input  logic                 clk,
   input  logic                 clr,
   input  term_pkg::cmd_t       cmd,
   input  term_pkg::byte_t      cmd_char,
   input  logic [ROW_BITS-1:0]  goto_row,
   input  logic [COL_BITS-1:0]  goto_col,
   output logic                 goto_busy,
   output logic                 put_req,
   output logic [ADDR_BITS-1:0] put_addr,
   output term_pkg::byte_t      put_char,
   output logic                 fill_req,
   output logic [ADDR_BITS-1:0] fill_first,
   output logic [ADDR_BITS-1:0] fill_last,
   output logic [COL_BITS-1:0]  new_cursor_x,
   output logic [ROW_BITS-1:0]  new_cursor_y,
   output logic                 new_cursor_wen,
   output logic [ADDR_BITS-1:0] new_first_char,
   output logic                 new_first_char_wen
);

   localparam LAST_ROW = (ROWS-1) * COLS;
   localparam BUF_SIZE = ROWS * COLS;

   typedef logic [ADDR_BITS-1:0] addr_t;
   // one extra bit holds origin plus row offset before the wrap
   typedef logic [ADDR_BITS:0]   wide_addr_t;
   typedef logic [ROW_BITS-1:0]  row_t;
   typedef logic [COL_BITS-1:0]  col_t;

   addr_t      row_addr;
   addr_t      char_addr;
   addr_t      row_down;
   addr_t      row_up;
   addr_t      origin_next;
   logic       on_last_row;
   wide_addr_t goto_sum;
   addr_t      goto_addr;
   logic       goto_s1;
   logic       goto_s2;

   assign on_last_row = (new_cursor_y == row_t'(ROWS-1));

   // neighbouring rows in the circular buffer
   assign row_down    = (row_addr == addr_t'(LAST_ROW)) ? '0 : row_addr + addr_t'(COLS);
   assign row_up      = (row_addr == '0) ? addr_t'(LAST_ROW) : row_addr - addr_t'(COLS);
   assign origin_next = (new_first_char == addr_t'(LAST_ROW)) ? '0
                                                             : new_first_char + addr_t'(COLS);

   assign put_req  = (cmd == term_pkg::cmd_print);
   assign put_addr = char_addr;
   assign put_char = cmd_char;

   // ESC K clears the rest of the cursor row, a scroll clears the row leaving the top
   assign fill_req = (cmd == term_pkg::cmd_erase_eol) || (cmd == term_pkg::cmd_lf && on_last_row);
   always_comb begin
      if (cmd == term_pkg::cmd_erase_eol) begin
         fill_first = char_addr;
         fill_last  = row_addr + addr_t'(COLS-1);
      end else begin
         fill_first = new_first_char;
         fill_last  = new_first_char + addr_t'(COLS-1);
      end
   end

   assign goto_busy = goto_s1 || goto_s2;

   // ESC Y address pipeline
   always_ff @(posedge clk) begin
      if (cmd == term_pkg::cmd_goto) begin
         goto_sum <= {1'b0, new_first_char} + wide_addr_t'(goto_row) * wide_addr_t'(COLS);
      end
      if (goto_s1) begin
         if (goto_sum >= wide_addr_t'(BUF_SIZE)) begin
            goto_addr <= addr_t'(goto_sum - wide_addr_t'(BUF_SIZE));
         end else begin
            goto_addr <= goto_sum[ADDR_BITS-1:0];
         end
      end
   end

   always_ff @(posedge clk or posedge clr) begin
      if (clr) begin
         new_cursor_x       <= '0;
         new_cursor_y       <= '0;
         new_cursor_wen     <= 1'b0;
         new_first_char     <= '0;
         new_first_char_wen <= 1'b0;
         row_addr           <= '0;
         char_addr          <= '0;
         goto_s1            <= 1'b0;
         goto_s2            <= 1'b0;
      end else begin
         // strobes are single cycle unless set again below
         new_cursor_wen     <= 1'b0;
         new_first_char_wen <= 1'b0;
         goto_s1            <= (cmd == term_pkg::cmd_goto);
         goto_s2            <= goto_s1;

         if (goto_s2) begin
            new_cursor_x   <= goto_col;
            new_cursor_y   <= goto_row;
            row_addr       <= goto_addr;
            char_addr      <= goto_addr + addr_t'(goto_col);
            new_cursor_wen <= 1'b1;
         end

         case (cmd)
            term_pkg::cmd_print, term_pkg::cmd_right: begin
               // no auto wrap at the right margin
               if (new_cursor_x != col_t'(COLS-1)) begin
                  new_cursor_x   <= new_cursor_x + 1'b1;
                  char_addr      <= char_addr + 1'b1;
                  new_cursor_wen <= 1'b1;
               end
            end
            term_pkg::cmd_left: begin
               if (new_cursor_x != '0) begin
                  new_cursor_x   <= new_cursor_x - 1'b1;
                  char_addr      <= char_addr - 1'b1;
                  new_cursor_wen <= 1'b1;
               end
            end
            term_pkg::cmd_up: begin
               if (new_cursor_y != '0) begin
                  new_cursor_y   <= new_cursor_y - 1'b1;
                  row_addr       <= row_up;
                  char_addr      <= row_up + addr_t'(new_cursor_x);
                  new_cursor_wen <= 1'b1;
               end
            end
            term_pkg::cmd_down, term_pkg::cmd_lf: begin
               if (!on_last_row) begin
                  new_cursor_y   <= new_cursor_y + 1'b1;
                  row_addr       <= row_down;
                  char_addr      <= row_down + addr_t'(new_cursor_x);
                  new_cursor_wen <= 1'b1;
               end else if (cmd == term_pkg::cmd_lf) begin
                  // scroll: the old top row becomes the new bottom row
                  new_first_char     <= origin_next;
                  new_first_char_wen <= 1'b1;
                  row_addr           <= row_down;
                  char_addr          <= row_down + addr_t'(new_cursor_x);
               end
            end
            term_pkg::cmd_cr: begin
               if (new_cursor_x != '0) begin
                  new_cursor_x   <= '0;
                  char_addr      <= row_addr;
                  new_cursor_wen <= 1'b1;
               end
            end
            term_pkg::cmd_home: begin
               new_cursor_x   <= '0;
               new_cursor_y   <= '0;
               row_addr       <= new_first_char;
               char_addr      <= new_first_char;
               new_cursor_wen <= 1'b1;
            end
            default: begin
            end
         endcase
      end
   end

endmodule

//--- screen_writer.sv
// screen writer: registered buffer write port for single characters and space fills
`timescale 1ns/1ns

module screen_writer #(
   parameter ROWS      = 24,
   parameter COLS      = 80,
   parameter ADDR_BITS = 11
) (
   input  logic                 clk,
   input  logic                 clr,
   input  logic                 put_req,
   input  logic [ADDR_BITS-1:0] put_addr,
   input  term_pkg::byte_t      put_char,
   input  logic                 fill_req,
   input  logic [ADDR_BITS-1:0] fill_first,
   input  logic [ADDR_BITS-1:0] fill_last,
   output logic                 fill_busy,
   output term_pkg::byte_t      new_char,
   output logic [ADDR_BITS-1:0] new_char_address,
   output logic                 new_char_wen
);

   localparam BUF_SIZE = ROWS * COLS;

   typedef logic [ADDR_BITS-1:0] addr_t;

   addr_t fill_end;
   addr_t fill_step;

   // the fill runs through the end of the buffer back to address 0
   assign fill_step = (new_char_address == addr_t'(BUF_SIZE-1)) ? '0 : new_char_address + 1'b1;

   always_ff @(posedge clk) begin
      if (fill_req && !fill_busy) begin
         fill_end <= fill_last;
      end
   end

   always_ff @(posedge clk or posedge clr) begin
      if (clr) begin
         fill_busy        <= 1'b0;
         new_char         <= '0;
         new_char_address <= '0;
         new_char_wen     <= 1'b0;
      end else if (fill_busy) begin
         // busy stays high for exactly the fill write cycles
         if (new_char_address == fill_end) begin
            fill_busy    <= 1'b0;
            new_char_wen <= 1'b0;
         end else begin
            new_char_address <= fill_step;
            new_char_wen     <= 1'b1;
         end
      end else if (fill_req) begin
         fill_busy        <= 1'b1;
         new_char         <= term_pkg::code_space;
         new_char_address <= fill_first;
         new_char_wen     <= 1'b1;
      end else if (put_req) begin
         new_char         <= put_char;
         new_char_address <= put_addr;
         new_char_wen     <= 1'b1;
      end else begin
         new_char_wen <= 1'b0;
      end
   end

endmodule

//--- vt52_command_handler.sv
// vt52 command handler top: byte parser, cursor unit and screen writer
`timescale 1ns/1ns

module vt52_command_handler #(
   parameter ROWS      = 24,
   parameter COLS      = 80,
   parameter ROW_BITS  = 5,
   parameter COL_BITS  = 7,
   parameter ADDR_BITS = 11
) (
   input  logic                 clk,
   input  logic                 clr,
   input  term_pkg::byte_t      data,
   input  logic                 valid,
   output logic                 ready,
   output term_pkg::byte_t      new_char,
   output logic [ADDR_BITS-1:0] new_char_address,
   output logic                 new_char_wen,
   output logic [COL_BITS-1:0]  new_cursor_x,
   output logic [ROW_BITS-1:0]  new_cursor_y,
   output logic                 new_cursor_wen,
   output logic [ADDR_BITS-1:0] new_first_char,
   output logic                 new_first_char_wen
);

   // decoder to cursor unit
   term_pkg::cmd_t        cmd;
   term_pkg::byte_t       cmd_char;
   logic [ROW_BITS-1:0]   goto_row;
   logic [COL_BITS-1:0]   goto_col;

   // cursor unit to screen writer
   logic                  put_req;
   logic [ADDR_BITS-1:0]  put_addr;
   term_pkg::byte_t       put_char;
   logic                  fill_req;
   logic [ADDR_BITS-1:0]  fill_first;
   logic [ADDR_BITS-1:0]  fill_last;

   // busy back to the decoder
   logic                  fill_busy;
   logic                  goto_busy;

   vt52_decoder #(
      .ROWS     (ROWS),
      .COLS     (COLS),
      .ROW_BITS (ROW_BITS),
      .COL_BITS (COL_BITS)
   ) u_decoder (
      .clk       (clk),
      .clr       (clr),
      .data      (data),
      .valid     (valid),
      .fill_busy (fill_busy),
      .goto_busy (goto_busy),
      .cursor_y  (new_cursor_y),
      .ready     (ready),
      .cmd       (cmd),
      .cmd_char  (cmd_char),
      .goto_row  (goto_row),
      .goto_col  (goto_col)
   );

   cursor_unit #(
      .ROWS      (ROWS),
      .COLS      (COLS),
      .ROW_BITS  (ROW_BITS),
      .COL_BITS  (COL_BITS),
      .ADDR_BITS (ADDR_BITS)
   ) u_cursor (
      .clk                (clk),
      .clr                (clr),
      .cmd                (cmd),
      .cmd_char           (cmd_char),
      .goto_row           (goto_row),
      .goto_col           (goto_col),
      .goto_busy          (goto_busy),
      .put_req            (put_req),
      .put_addr           (put_addr),
      .put_char           (put_char),
      .fill_req           (fill_req),
      .fill_first         (fill_first),
      .fill_last          (fill_last),
      .new_cursor_x       (new_cursor_x),
      .new_cursor_y       (new_cursor_y),
      .new_cursor_wen     (new_cursor_wen),
      .new_first_char     (new_first_char),
      .new_first_char_wen (new_first_char_wen)
   );

   screen_writer #(
      .ROWS      (ROWS),
      .COLS      (COLS),
      .ADDR_BITS (ADDR_BITS)
   ) u_writer (
      .clk              (clk),
      .clr              (clr),
      .put_req          (put_req),
      .put_addr         (put_addr),
      .put_char         (put_char),
      .fill_req         (fill_req),
      .fill_first       (fill_first),
      .fill_last        (fill_last),
      .fill_busy        (fill_busy),
      .new_char         (new_char),
      .new_char_address (new_char_address),
      .new_char_wen     (new_char_wen)
   );

endmodule

//--- vt52_sva.sv
// vt52 handler assertions: strobe width, ready after reset and buffer address range
`timescale 1ns/1ns

module vt52_sva #(
   parameter ROWS      = 24,
   parameter COLS      = 80,
   parameter ADDR_BITS = 11
) (
   input logic                 clk,
   input logic                 clr,
   input logic                 ready,
   input logic                 new_char_wen,
   input logic [ADDR_BITS-1:0] new_char_address,
   input logic                 new_cursor_wen,
   input logic                 new_first_char_wen
);

   localparam BUF_SIZE = ROWS * COLS;

   cursor_wen_single: assert property (@(posedge clk) disable iff (clr)
      new_cursor_wen |=> !new_cursor_wen)
      else $error("cursor strobe held for more than one cycle");

   first_char_wen_single: assert property (@(posedge clk) disable iff (clr)
      new_first_char_wen |=> !new_first_char_wen)
      else $error("origin strobe held for more than one cycle");

   ready_after_reset: assert property (@(posedge clk) $fell(clr) |-> ready)
      else $error("ready low after reset");

   address_in_buffer: assert property (@(posedge clk) disable iff (clr)
      new_char_wen |-> (new_char_address < ADDR_BITS'(BUF_SIZE)))
      else $error("write address beyond the screen buffer");

endmodule

bind vt52_command_handler vt52_sva #(
   .ROWS      (ROWS),
   .COLS      (COLS),
   .ADDR_BITS (ADDR_BITS)
) u_sva (
   .clk                (clk),
   .clr                (clr),
   .ready              (ready),
   .new_char_wen       (new_char_wen),
   .new_char_address   (new_char_address),
   .new_cursor_wen     (new_cursor_wen),
   .new_first_char_wen (new_first_char_wen)
);

//--- tb_vt52.sv
// testbench for the vt52 command handler with an LFSR byte stream checked against a model
`timescale 1ns/1ns

module tb_vt52;

   localparam ROWS       = 24;
   localparam COLS       = 80;
   localparam ROW_BITS   = 5;
   localparam COL_BITS   = 7;
   localparam ADDR_BITS  = 11;
   localparam BUF_SIZE   = ROWS * COLS;
   localparam NUM_BYTES  = 3000;
   localparam CLK_PERIOD = 40;
   localparam longint WATCHDOG_NS = longint'(NUM_BYTES) * (COLS + 6) * CLK_PERIOD;

   logic                 clk;
   logic                 clr;
   term_pkg::byte_t      data;
   logic                 valid;
   logic                 ready;
   term_pkg::byte_t      new_char;
   logic [ADDR_BITS-1:0] new_char_address;
   logic                 new_char_wen;
   logic [COL_BITS-1:0]  new_cursor_x;
   logic [ROW_BITS-1:0]  new_cursor_y;
   logic                 new_cursor_wen;
   logic [ADDR_BITS-1:0] new_first_char;
   logic                 new_first_char_wen;

   // random source
   logic [31:0] lfsr;

   // terminal model with parser state 0 normal, 1 after ESC, 2 ESC Y row and 3 ESC Y column
   int              m_x;
   int              m_y;
   int              m_origin;
   int              m_state;
   int              m_goto_row;
   term_pkg::byte_t model_screen [0:BUF_SIZE-1];
   term_pkg::byte_t shadow [0:BUF_SIZE-1];

   // expected response to the current byte
   int exp_cursor_wen;
   int exp_cursor_delay;
   int exp_first_wen;
   int exp_writes;

   // observed response
   int cyc;
   int write_count;
   int cursor_wen_count;
   int cursor_wen_cyc;
   int first_wen_count;
   int error_count;

   vt52_command_handler UUT (
      .clk                (clk),
      .clr                (clr),
      .data               (data),
      .valid              (valid),
      .ready              (ready),
      .new_char           (new_char),
      .new_char_address   (new_char_address),
      .new_char_wen       (new_char_wen),
      .new_cursor_x       (new_cursor_x),
      .new_cursor_y       (new_cursor_y),
      .new_cursor_wen     (new_cursor_wen),
      .new_first_char     (new_first_char),
      .new_first_char_wen (new_first_char_wen)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   // capture DUT writes and strobes in the middle of the cycle
   always @(negedge clk) begin
      if (!clr) begin
         if (new_char_wen) begin
            shadow[new_char_address] = new_char;
            write_count++;
         end
         if (new_cursor_wen) begin
            cursor_wen_count++;
            cursor_wen_cyc = cyc;
         end
         if (new_first_char_wen) begin
            first_wen_count++;
         end
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("timeout: the byte stream did not complete in time");
      $display("sim failed");
      $fatal(1, "watchdog expired");
   end

   // galois LFSR stepped once per bit taken
   function automatic int take_bits(input int n);
      int   value;
      logic lsb;
      value = 0;
      for (int i = 0; i < n; i++) begin
         lsb  = lfsr[0];
         lfsr = lfsr >> 1;
         if (lsb) begin
            lfsr = lfsr ^ 32'hB4BC_D35C;
         end
         value = (value << 1) | int'(lsb);
      end
      return value;
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (expected === actual) else begin
         error_count++;
         $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
         $display("sim failed");
         $fatal(1, "check failed");
      end
   endtask

   // choose the next byte from the parser state of the model
   function automatic term_pkg::byte_t pick_byte();
      int k;
      case (m_state)
         0: begin
            k = take_bits(4);
            if (k < 8) begin
               return term_pkg::byte_t'(32 + take_bits(7) % 95);
            end
            case (k)
               8:       return term_pkg::code_bs;
               9:       return term_pkg::code_cr;
               10, 11:  return term_pkg::code_lf;
               12, 13:  return term_pkg::code_esc;
               14:      return term_pkg::byte_t'(take_bits(5));
               default: return term_pkg::byte_t'(128 + take_bits(7));
            endcase
         end
         1: begin
            k = take_bits(4);
            case (k)
               0:       return "A";
               1:       return "B";
               2:       return "C";
               3:       return "D";
               4:       return "H";
               5:       return "K";
               6, 7:    return "Y";
               8:       return term_pkg::code_esc;
               9:       return "I";
               10:      return "J";
               11:      return "Z";
               default: return term_pkg::byte_t'(64 + take_bits(5));
            endcase
         end
         2: begin
            // some coordinates fall outside the screen
            if (take_bits(3) == 0) begin
               return term_pkg::byte_t'(take_bits(8));
            end
            return term_pkg::byte_t'(32 + take_bits(5) % ROWS);
         end
         default: begin
            if (take_bits(3) == 0) begin
               return term_pkg::byte_t'(take_bits(8));
            end
            return term_pkg::byte_t'(32 + take_bits(7) % COLS);
         end
      endcase
   endfunction

   task automatic fill_spaces(input int first, input int count);
      for (int i = 0; i < count; i++) begin
         model_screen[(first + i) % BUF_SIZE] = term_pkg::code_space;
      end
      exp_writes = count;
   endtask

   // apply one byte to the model and set the expected strobes
   task automatic model_byte(input term_pkg::byte_t b);
      int v;
      int row_addr;
      v                = int'(b);
      row_addr         = (m_origin + m_y * COLS) % BUF_SIZE;
      exp_cursor_wen   = 0;
      exp_cursor_delay = 0;
      exp_first_wen    = 0;
      exp_writes       = 0;
      case (m_state)
         0: begin
            if (v >= 32 && v <= 126) begin
               model_screen[row_addr + m_x] = b;
               exp_writes = 1;
               if (m_x != COLS - 1) begin
                  m_x++;
                  exp_cursor_wen = 1;
               end
            end else if (v == 8) begin
               if (m_x != 0) begin
                  m_x--;
                  exp_cursor_wen = 1;
               end
            end else if (v == 13) begin
               if (m_x != 0) begin
                  m_x = 0;
                  exp_cursor_wen = 1;
               end
            end else if (v == 10) begin
               if (m_y != ROWS - 1) begin
                  m_y++;
                  exp_cursor_wen = 1;
               end else begin
                  // a scroll blanks the old top row, which becomes the bottom row
                  fill_spaces(m_origin, COLS);
                  m_origin      = (m_origin + COLS) % BUF_SIZE;
                  exp_first_wen = 1;
               end
            end else if (v == 27) begin
               m_state = 1;
            end
         end
         1: begin
            m_state = 0;
            case (v)
               65: if (m_y != 0) begin
                  m_y--;
                  exp_cursor_wen = 1;
               end
               66: if (m_y != ROWS - 1) begin
                  m_y++;
                  exp_cursor_wen = 1;
               end
               67: if (m_x != COLS - 1) begin
                  m_x++;
                  exp_cursor_wen = 1;
               end
               68: if (m_x != 0) begin
                  m_x--;
                  exp_cursor_wen = 1;
               end
               72: begin
                  m_x = 0;
                  m_y = 0;
                  exp_cursor_wen = 1;
               end
               75: fill_spaces(row_addr + m_x, COLS - m_x);
               89: m_state = 2;
               27: m_state = 1;
               default: m_state = 0;
            endcase
         end
         2: begin
            m_goto_row = (v >= 32 && v - 32 < ROWS) ? v - 32 : m_y;
            m_state    = 3;
         end
         default: begin
            m_x = (v >= 32 && v - 32 < COLS) ? v - 32 : COLS - 1;
            m_y = m_goto_row;
            // strobe comes two cycles later than for a plain cursor move
            exp_cursor_wen   = 1;
            exp_cursor_delay = 2;
            m_state          = 0;
         end
      endcase
   endtask

   // offer one byte and drive junk on the bus while ready is low
   task automatic send_byte(input term_pkg::byte_t b);
      int gap;
      int waited;
      int accept_cyc;
      gap = take_bits(2);
      repeat (gap) begin
         @(posedge clk);
         #2;
      end
      check_value("ready before byte", 1, 32'(ready));
      write_count      = 0;
      cursor_wen_count = 0;
      first_wen_count  = 0;
      data  = b;
      valid = 1'b1;
      @(posedge clk);
      #2;
      accept_cyc = cyc;
      waited     = 0;
      do begin
         if (ready) begin
            valid = 1'b0;
         end else begin
            valid = 1'b1;
            data  = term_pkg::byte_t'(take_bits(8));
         end
         @(posedge clk);
         #2;
         waited++;
      end while (!(ready && waited >= 4));
      valid = 1'b0;
      check_value("cursor strobes", exp_cursor_wen, cursor_wen_count);
      if (exp_cursor_wen != 0) begin
         check_value("cursor strobe delay", exp_cursor_delay, cursor_wen_cyc - accept_cyc);
      end
      check_value("origin strobes", exp_first_wen, first_wen_count);
      check_value("char writes", exp_writes, write_count);
   endtask

   task automatic compare_state();
      check_value("cursor x", m_x, 32'(new_cursor_x));
      check_value("cursor y", m_y, 32'(new_cursor_y));
      check_value("origin", m_origin, 32'(new_first_char));
      for (int i = 0; i < BUF_SIZE; i++) begin
         if (shadow[i] !== model_screen[i]) begin
            check_value($sformatf("screen[%0d]", i), 32'(model_screen[i]), 32'(shadow[i]));
         end
      end
   endtask

   initial begin
      term_pkg::byte_t b;
      lfsr        = 32'h43a1_4a0f;
      cyc         = 0;
      error_count = 0;
      m_x         = 0;
      m_y         = 0;
      m_origin    = 0;
      m_state     = 0;
      m_goto_row  = 0;
      data        = '0;
      valid       = 1'b0;
      clr         = 1'b1;
      for (int i = 0; i < BUF_SIZE; i++) begin
         model_screen[i] = '0;
         shadow[i]       = '0;
      end
      repeat (5) @(posedge clk);
      #2;
      clr = 1'b0;
      check_value("ready after reset", 1, 32'(ready));
      check_value("char wen after reset", 0, 32'(new_char_wen));
      check_value("cursor wen after reset", 0, 32'(new_cursor_wen));
      compare_state();

      for (int n = 0; n < NUM_BYTES; n++) begin
         b = pick_byte();
         model_byte(b);
         send_byte(b);
         compare_state();
      end

      if (error_count == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

//--- verilog.f
term_pkg.sv
vt52_decoder.sv
cursor_unit.sv
screen_writer.sv
vt52_command_handler.sv
vt52_sva.sv
tb_vt52.sv

//--- run_sim.sh
#!/bin/bash
# build and run the vt52 handler simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_vt52 -o sim_vt52
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

output=$(./obj_dir/sim_vt52 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
   exit 0
fi
exit 1
